/* design/rv_commit_cfg.svh */
`ifndef RV_COMMIT_CFG_SVH
`define RV_COMMIT_CFG_SVH

// Register width
`define XLEN 32

// Retire lanes per cycle
`define COMMIT_WIDTH 2

// Commit queue entries, a power of two
`define CQ_DEPTH 8

// Architectural integer registers, x0 included
`define NUM_AREGS 32

`endif

/* design/rv_commit_pkg.sv */
`include "rv_commit_cfg.svh"

package rv_commit_pkg;

    // One register value
    typedef logic [`XLEN-1:0] xdata_t;

    // Architectural register index, also the Wishbone read address
    typedef logic [$clog2(`NUM_AREGS)-1:0] areg_idx_t;

    // Queue pointer with one extra wrap bit to tell full from empty
    typedef logic [$clog2(`CQ_DEPTH):0] cq_ptr_t;

    // Read arbiter FSM
    typedef enum logic [1:0] {
        idle,
        busy_m0,
        busy_m1
    } arb_state_t;

endpackage

/* design/commit_queue.sv */
`include "rv_commit_cfg.svh"

module commit_queue (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           push,
    input  rv_commit_pkg::areg_idx_t       push_idx,
    input  rv_commit_pkg::xdata_t          push_data,
    output logic                           push_ready,

    input  logic                           hold,

    output logic [`COMMIT_WIDTH-1:0]       cm_vld,
    output rv_commit_pkg::areg_idx_t       cm_idx [`COMMIT_WIDTH],
    output rv_commit_pkg::xdata_t          cm_data [`COMMIT_WIDTH]
);

    import rv_commit_pkg::*;

    localparam int ADDR_W = $clog2(`CQ_DEPTH);

    // Entry storage
    areg_idx_t idx_mem [`CQ_DEPTH];
    xdata_t    data_mem [`CQ_DEPTH];

    cq_ptr_t wr_ptr;
    cq_ptr_t rd_ptr;
    cq_ptr_t count;
    cq_ptr_t retire_cnt;
    logic    full;
    logic    push_fire;

    assign count      = wr_ptr - rd_ptr;
    assign full       = (count == cq_ptr_t'(`CQ_DEPTH));
    assign push_ready = !full;
    assign push_fire  = push && push_ready;

    // Oldest entries go out on the lanes in age order, lane 0 first
    always_comb begin
        cq_ptr_t slot;
        retire_cnt = '0;
        for (int l = 0; l < `COMMIT_WIDTH; l++) begin
            slot       = rd_ptr + cq_ptr_t'(l);
            cm_vld[l]  = !hold && (cq_ptr_t'(l) < count);
            cm_idx[l]  = idx_mem[slot[ADDR_W-1:0]];
            cm_data[l] = data_mem[slot[ADDR_W-1:0]];
            if (cm_vld[l]) begin
                retire_cnt = retire_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr + retire_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            idx_mem[wr_ptr[ADDR_W-1:0]]  <= push_idx;
            data_mem[wr_ptr[ADDR_W-1:0]] <= push_data;
        end
    end

    // The write pointer only moves when a slot was free the cycle before
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst)
        (wr_ptr != $past(wr_ptr)) |-> ($past(count) < cq_ptr_t'(`CQ_DEPTH))
    ) else $error("commit queue accepted a push while full");

    a_count_in_range: assert property (
        @(posedge clk) disable iff (rst)
        count <= cq_ptr_t'(`CQ_DEPTH)
    ) else $error("commit queue occupancy above depth");

endmodule

/* design/arch_regfile.sv */
`include "rv_commit_cfg.svh"

module arch_regfile (
    input  logic                           clk,
    input  logic                           rst,

    // Retire lanes, lane 0 oldest
    input  logic [`COMMIT_WIDTH-1:0]       cm_vld,
    input  rv_commit_pkg::areg_idx_t       cm_idx [`COMMIT_WIDTH],
    input  rv_commit_pkg::xdata_t          cm_data [`COMMIT_WIDTH],

    // Wishbone classic read slave
    input  logic                           s_cyc,
    input  logic                           s_stb,
    input  rv_commit_pkg::areg_idx_t       s_adr,
    output logic                           s_ack,
    output rv_commit_pkg::xdata_t          s_dat
);

    import rv_commit_pkg::*;

    xdata_t regs [`NUM_AREGS];
    xdata_t regs_next [`NUM_AREGS];
    logic   rd_accept;

    // Merge the lanes oldest first so a younger lane to the same register wins
    always_comb begin
        regs_next = regs;
        for (int l = 0; l < `COMMIT_WIDTH; l++) begin
            if (cm_vld[l] && (cm_idx[l] != '0)) begin
                regs_next[cm_idx[l]] = cm_data[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NUM_AREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            regs <= regs_next;
        end
    end

    // New request only when the previous ack has gone
    assign rd_accept = s_cyc && s_stb && !s_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            s_ack <= 1'b0;
        end else begin
            s_ack <= rd_accept;
        end
    end

    // Read sees this cycle's commits
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            s_dat <= regs_next[s_adr];
        end
    end

    a_single_cycle_ack: assert property (
        @(posedge clk) disable iff (rst)
        s_ack |=> !s_ack
    ) else $error("register file ack held for two cycles");

endmodule

/* design/wb_read_arbiter.sv */
`include "rv_commit_cfg.svh"

module wb_read_arbiter (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           m0_cyc,
    input  logic                           m0_stb,
    input  rv_commit_pkg::areg_idx_t       m0_adr,
    output logic                           m0_ack,
    output rv_commit_pkg::xdata_t          m0_dat,

    input  logic                           m1_cyc,
    input  logic                           m1_stb,
    input  rv_commit_pkg::areg_idx_t       m1_adr,
    output logic                           m1_ack,
    output rv_commit_pkg::xdata_t          m1_dat,

    output logic                           s_cyc,
    output logic                           s_stb,
    output rv_commit_pkg::areg_idx_t       s_adr,
    input  logic                           s_ack,
    input  rv_commit_pkg::xdata_t          s_dat
);

    import rv_commit_pkg::*;

    arb_state_t state;
    arb_state_t state_next;
    logic       last_m1;
    logic       req0;
    logic       req1;
    logic       grant_m0;
    logic       grant_m1;
    logic       sel_m0;
    logic       sel_m1;

    assign req0 = m0_cyc && m0_stb;
    assign req1 = m1_cyc && m1_stb;

    // On a tie the master not served last goes first
    assign grant_m1 = (state == idle) && req1 && (!req0 || !last_m1);
    assign grant_m0 = (state == idle) && req0 && !grant_m1;

    assign sel_m0 = grant_m0 || (state == busy_m0);
    assign sel_m1 = grant_m1 || (state == busy_m1);

    assign s_cyc = (sel_m0 && m0_cyc) || (sel_m1 && m1_cyc);
    assign s_stb = (sel_m0 && m0_stb) || (sel_m1 && m1_stb);
    assign s_adr = sel_m1 ? m1_adr : m0_adr;

    assign m0_ack = s_ack && (state == busy_m0);
    assign m1_ack = s_ack && (state == busy_m1);
    assign m0_dat = (state == busy_m0) ? s_dat : '0;
    assign m1_dat = (state == busy_m1) ? s_dat : '0;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (grant_m0) begin
                    state_next = busy_m0;
                end else if (grant_m1) begin
                    state_next = busy_m1;
                end
            end
            busy_m0, busy_m1: begin
                if (s_ack) begin
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            last_m1 <= 1'b0;
        end else begin
            state <= state_next;
            if (grant_m1) begin
                last_m1 <= 1'b1;
            end else if (grant_m0) begin
                last_m1 <= 1'b0;
            end
        end
    end

    a_one_ack: assert property (
        @(posedge clk) disable iff (rst)
        !(m0_ack && m1_ack)
    ) else $error("both masters acked in the same cycle");

endmodule

/* design/rv_commit_top.sv */
`include "rv_commit_cfg.svh"

module rv_commit_top (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           push,
    input  rv_commit_pkg::areg_idx_t       push_idx,
    input  rv_commit_pkg::xdata_t          push_data,
    output logic                           push_ready,
    input  logic                           hold,

    // Debug host
    input  logic                           m0_cyc,
    input  logic                           m0_stb,
    input  rv_commit_pkg::areg_idx_t       m0_adr,
    output logic                           m0_ack,
    output rv_commit_pkg::xdata_t          m0_dat,

    // Trace host
    input  logic                           m1_cyc,
    input  logic                           m1_stb,
    input  rv_commit_pkg::areg_idx_t       m1_adr,
    output logic                           m1_ack,
    output rv_commit_pkg::xdata_t          m1_dat
);

    import rv_commit_pkg::*;

    logic [`COMMIT_WIDTH-1:0] cm_vld;
    areg_idx_t                cm_idx [`COMMIT_WIDTH];
    xdata_t                   cm_data [`COMMIT_WIDTH];

    logic      s_cyc;
    logic      s_stb;
    areg_idx_t s_adr;
    logic      s_ack;
    xdata_t    s_dat;

    commit_queue u_commit_queue (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_idx   (push_idx),
        .push_data  (push_data),
        .push_ready (push_ready),
        .hold       (hold),
        .cm_vld     (cm_vld),
        .cm_idx     (cm_idx),
        .cm_data    (cm_data)
    );

    arch_regfile u_arch_regfile (
        .clk     (clk),
        .rst     (rst),
        .cm_vld  (cm_vld),
        .cm_idx  (cm_idx),
        .cm_data (cm_data),
        .s_cyc   (s_cyc),
        .s_stb   (s_stb),
        .s_adr   (s_adr),
        .s_ack   (s_ack),
        .s_dat   (s_dat)
    );

    wb_read_arbiter u_wb_read_arbiter (
        .clk    (clk),
        .rst    (rst),
        .m0_cyc (m0_cyc),
        .m0_stb (m0_stb),
        .m0_adr (m0_adr),
        .m0_ack (m0_ack),
        .m0_dat (m0_dat),
        .m1_cyc (m1_cyc),
        .m1_stb (m1_stb),
        .m1_adr (m1_adr),
        .m1_ack (m1_ack),
        .m1_dat (m1_dat),
        .s_cyc  (s_cyc),
        .s_stb  (s_stb),
        .s_adr  (s_adr),
        .s_ack  (s_ack),
        .s_dat  (s_dat)
    );

endmodule

/* testbench/commit_checker.sv */
`include "rv_commit_cfg.svh"

module commit_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  rv_commit_pkg::areg_idx_t push_idx,
    input  rv_commit_pkg::xdata_t    push_data,
    input  logic                     push_ready,
    input  logic                     hold,
    input  logic                     m0_cyc,
    input  logic                     m0_stb,
    input  rv_commit_pkg::areg_idx_t m0_adr,
    input  logic                     m0_ack,
    input  rv_commit_pkg::xdata_t    m0_dat,
    input  logic                     m1_cyc,
    input  logic                     m1_stb,
    input  rv_commit_pkg::areg_idx_t m1_adr,
    input  logic                     m1_ack,
    input  rv_commit_pkg::xdata_t    m1_dat,
    output int                       checks,
    output int                       errors
);

    import rv_commit_pkg::*;

    areg_idx_t q_idx [$];
    xdata_t    q_data [$];
    xdata_t    regs [`NUM_AREGS];
    // Merged state of the previous cycle, where the acked read was accepted
    xdata_t    prev_regs [`NUM_AREGS];
    areg_idx_t prev_adr0;
    areg_idx_t prev_adr1;
    logic      prev_req0;
    logic      prev_req1;
    int        last_acker;

    task automatic check_read(input int host, input xdata_t got, input areg_idx_t adr,
                              input logic other_req);
        checks++;
        if (got !== prev_regs[adr]) begin
            errors++;
            $display("Mismatch at %0t: host %0d read x%0d as %h, expected %h",
                     $time, host, adr, got, prev_regs[adr]);
        end
        if (last_acker == host && other_req) begin
            errors++;
            $display("At %0t host %0d was served twice while the other host waited",
                     $time, host);
        end
        last_acker = host;
    endtask

    always @(posedge clk) begin : model_step
        logic ready;
        ready = q_idx.size() < `CQ_DEPTH;
        if (rst) begin
            q_idx.delete();
            q_data.delete();
            for (int r = 0; r < `NUM_AREGS; r++) begin
                regs[r] = '0;
            end
            prev_regs  = regs;
            prev_req0  = 1'b0;
            prev_req1  = 1'b0;
            last_acker = -1;
            checks     = 0;
            errors     = 0;
        end else begin
            checks++;
            if (push_ready !== ready) begin
                errors++;
                $display("Mismatch at %0t: push_ready is %b, expected %b",
                         $time, push_ready, ready);
            end
            if (m0_ack && m1_ack) begin
                errors++;
                $display("Both hosts received an ack in the same cycle at %0t", $time);
            end
            if (m0_ack) begin
                check_read(0, m0_dat, prev_adr0, prev_req1);
            end
            if (m1_ack) begin
                check_read(1, m1_dat, prev_adr1, prev_req0);
            end
            // Oldest first, so a younger write to the same register lands last
            if (!hold) begin
                for (int l = 0; l < `COMMIT_WIDTH; l++) begin
                    if (q_idx.size() > 0) begin
                        if (q_idx[0] != '0) begin
                            regs[q_idx[0]] = q_data[0];
                        end
                        void'(q_idx.pop_front());
                        void'(q_data.pop_front());
                    end
                end
            end
            if (push && ready) begin
                q_idx.push_back(push_idx);
                q_data.push_back(push_data);
            end
            prev_regs = regs;
        end
        prev_adr0 = m0_adr;
        prev_adr1 = m1_adr;
        prev_req0 = m0_cyc && m0_stb;
        prev_req1 = m1_cyc && m1_stb;
    end

endmodule

/* testbench/tb_rv_commit.sv */
`include "rv_commit_cfg.svh"

module tb_rv_commit;

    import rv_commit_pkg::*;

    localparam int DRIVE_DLY    = 5;
    localparam int ACK_TIMEOUT  = 50;
    localparam int FILL_TIMEOUT = 4 * `CQ_DEPTH;

    logic      clk;
    logic      rst;
    logic      push;
    areg_idx_t push_idx;
    xdata_t    push_data;
    logic      push_ready;
    logic      hold;
    logic      m0_cyc;
    logic      m0_stb;
    areg_idx_t m0_adr;
    logic      m0_ack;
    xdata_t    m0_dat;
    logic      m1_cyc;
    logic      m1_stb;
    areg_idx_t m1_adr;
    logic      m1_ack;
    xdata_t    m1_dat;
    int        checks;
    int        errors;
    int        tb_errors;
    int        seed;

    rv_commit_top DUT (.*);

    commit_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic drive_req(input int host, input logic req, input areg_idx_t adr);
        if (host == 0) begin
            m0_cyc = req;
            m0_stb = req;
            m0_adr = adr;
        end else begin
            m1_cyc = req;
            m1_stb = req;
            m1_adr = adr;
        end
    endtask

    task automatic wait_ack(input int host);
        int   cycles;
        logic got;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            got = (host == 0) ? m0_ack : m1_ack;
            cycles++;
        end
        if (!got) begin
            $display("Timeout: host %0d received no ack within %0d cycles", host, ACK_TIMEOUT);
            tb_errors++;
        end
    endtask

    task automatic read_reg(input int host, input areg_idx_t adr);
        drive_req(host, 1'b1, adr);
        wait_ack(host);
        #DRIVE_DLY;
        drive_req(host, 1'b0, '0);
    endtask

    // A gap of zero keeps the host requesting back to back
    task automatic host_reads(input int host, input int n, input int max_gap);
        int gap;
        for (int i = 0; i < n; i++) begin
            gap = $unsigned($random(seed)) % (max_gap + 1);
            if (gap > 0) begin
                repeat (gap) @(posedge clk);
                #DRIVE_DLY;
            end
            read_reg(host, areg_idx_t'($random(seed)));
        end
    endtask

    task automatic random_traffic(input int cycles);
        repeat (cycles) begin
            hold      = ($random(seed) & 3) == 0;
            push      = $random(seed) & 1;
            push_idx  = areg_idx_t'($random(seed));
            push_data = $random(seed);
            @(posedge clk);
            #DRIVE_DLY;
        end
        hold = 1'b0;
        push = 1'b0;
    endtask

    // Pairs of entries share a register so both lanes hit it in one retire
    task automatic fill_while_held();
        int   accepted;
        int   cycles;
        logic ready;
        accepted = 0;
        cycles   = 0;
        ready    = 1'b1;
        hold     = 1'b1;
        push     = 1'b1;
        while (ready && cycles < FILL_TIMEOUT) begin
            push_idx  = areg_idx_t'(8 + accepted / 2);
            push_data = $random(seed);
            @(posedge clk);
            ready = push_ready;
            if (ready) begin
                accepted++;
            end
            cycles++;
            #DRIVE_DLY;
        end
        push = 1'b0;
        if (ready) begin
            $display("Timeout: push_ready never fell while hold was high");
            tb_errors++;
        end else if (accepted != `CQ_DEPTH) begin
            $display("Queue took %0d pushes before push_ready fell, expected %0d",
                     accepted, `CQ_DEPTH);
            tb_errors++;
        end
    endtask

    initial begin
        seed      = 32'h87e;
        tb_errors = 0;
        rst       = 1'b1;
        push      = 1'b0;
        push_idx  = '0;
        push_data = '0;
        hold      = 1'b0;
        drive_req(0, 1'b0, '0);
        drive_req(1, 1'b0, '0);
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        // Fresh register file
        fork
            host_reads(0, 6, 1);
            host_reads(1, 6, 1);
        join
        fork
            random_traffic(400);
            host_reads(0, 60, 3);
            host_reads(1, 60, 3);
        join
        fork
            random_traffic(200);
            host_reads(0, 40, 0);
            host_reads(1, 40, 0);
        join

        // Queue drains at COMMIT_WIDTH entries per cycle
        repeat (`CQ_DEPTH / `COMMIT_WIDTH) @(posedge clk);
        #DRIVE_DLY;
        fill_while_held();
        hold = 1'b0;
        fork
            begin
                read_reg(0, '0);
                for (int r = 8; r < 12; r++) begin
                    read_reg(0, areg_idx_t'(r));
                end
            end
            begin
                for (int r = 11; r >= 8; r--) begin
                    read_reg(1, areg_idx_t'(r));
                end
                read_reg(1, '0);
            end
        join

        repeat (2) @(posedge clk);
        $display("Checks: %0d, mismatches: %0d, testbench errors: %0d",
                 checks, errors, tb_errors);
        if (errors == 0 && tb_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+design
design/rv_commit_pkg.sv
design/commit_queue.sv
design/arch_regfile.sv
design/wb_read_arbiter.sv
design/rv_commit_top.sv
testbench/commit_checker.sv
testbench/tb_rv_commit.sv

/* Bender.yml */
package:
  name: rv_commit

sources:
  - include_dirs:
      - design
    files:
      - design/rv_commit_pkg.sv
      - design/commit_queue.sv
      - design/arch_regfile.sv
      - design/wb_read_arbiter.sv
      - design/rv_commit_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - testbench/commit_checker.sv
      - testbench/tb_rv_commit.sv
